//--- src/hyperbus_pkg.sv
package hyperbus_pkg;

	// phase of one bus operation, in the order the phases run
	typedef enum logic [2:0] {
		IDLE,
		PRE,
		CA,
		LATENCY,
		WRITE,
		READ,
		POST
	} hb_phase_e;

	typedef logic [7:0] hb_byte_t;
	typedef logic [5:0] hb_cnt_t;
	typedef logic [2:0] hb_rdcnt_t;

	// bytes moved in each data carrying phase
	localparam int unsigned CA_BYTES = 6;
	localparam int unsigned MEM_BYTES = 4;
	localparam int unsigned REG_BYTES = 2;

	typedef struct packed {
		logic     rstn;
		logic     csn;
		logic     clk;
		logic     clkn;
		logic     rwds;
		logic     rwds_oen;
		hb_byte_t dq;
		logic     dq_oen;
	} hb_pins_o_t;

	// device pins driven by the tx side, the bus clock is added at the top
	typedef struct packed {
		logic     rstn;
		logic     csn;
		logic     rwds;
		logic     rwds_oen;
		hb_byte_t dq;
		logic     dq_oen;
	} hb_tx_t;

	typedef struct packed {
		logic     rwds;
		hb_byte_t dq;
	} hb_pins_i_t;

	typedef struct packed {
		hb_phase_e phase;
		hb_cnt_t   cnt;
		logic      read_op;
		logic      reg_access;
	} hb_seq_t;

endpackage

//--- src/hyperram_cfg_pkg.sv
package hyperram_cfg_pkg;

	// timing fields count controller clock cycles
	typedef logic [3:0] hb_tcyc_t;
	typedef logic [4:0] hb_tmax_t;
	typedef logic [31:0] hb_word_t;

	typedef struct packed {
		hb_tcyc_t tcsh;
		hb_tcyc_t tpre;
		hb_tcyc_t tpost;
		hb_tcyc_t tacc;
		hb_tmax_t trmax;
		logic     fixed_latency;
		logic     double_latency;
	} hb_timing_t;

	typedef struct packed {
		logic       wren;
		logic       regspace;
		logic [31:0] addr;
		logic [3:0] sel;
		hb_word_t   data;
	} hb_req_t;

	localparam hb_tcyc_t MIN_TACC = 4'd2;
	localparam hb_tmax_t MIN_TIMEOUT = 5'd4;

	// device defaults to fixed 2x latency after its own reset
	localparam hb_timing_t DEFAULT_TIMING = '{
		tcsh:           4'd4,
		tpre:           4'd4,
		tpost:          4'd4,
		tacc:           4'd6,
		trmax:          5'd20,
		fixed_latency:  1'b1,
		double_latency: 1'b1
	};

endpackage

//--- src/hyperram_tx.sv
`timescale 1ns/1ps

module hyperram_tx
	import hyperbus_pkg::*, hyperram_cfg_pkg::*;
(
	input  logic    rst_i,
	input  hb_seq_t seq_i,
	input  hb_req_t req_i,
	output hb_tx_t  tx_o
);

	logic [47:0] ca_word;
	hb_byte_t    dq_byte;
	logic        mem_write;

	// command-address: r/w, space, linear burst, then the word address
	assign ca_word = {seq_i.read_op, seq_i.reg_access, 1'b1, req_i.addr[31:3],
		13'h0000, req_i.addr[2:0]};

	// rwds is the byte mask only for memory writes
	assign mem_write = (seq_i.phase == WRITE) && !seq_i.reg_access;

	always_comb begin
		dq_byte = '0;
		case (seq_i.phase)
			CA: begin
				case (seq_i.cnt)
					6'd5: dq_byte = ca_word[47:40];
					6'd4: dq_byte = ca_word[39:32];
					6'd3: dq_byte = ca_word[31:24];
					6'd2: dq_byte = ca_word[23:16];
					6'd1: dq_byte = ca_word[15:8];
					6'd0: dq_byte = ca_word[7:0];
					default: dq_byte = '0;
				endcase
			end
			WRITE: begin
				// counter runs down, so the high byte goes out first
				dq_byte = req_i.data[{seq_i.cnt[1:0], 3'b000} +: 8];
			end
			default: begin
				dq_byte = '0;
			end
		endcase
	end

	assign tx_o.rstn = ~rst_i;
	assign tx_o.csn = (seq_i.phase == IDLE);
	assign tx_o.rwds = mem_write ? ~req_i.sel[seq_i.cnt[1:0]] : 1'b0;
	assign tx_o.rwds_oen = mem_write;
	assign tx_o.dq = dq_byte;
	assign tx_o.dq_oen = (seq_i.phase == CA) || (seq_i.phase == WRITE);

endmodule

//--- src/hyperram_ddr_side.sv
`timescale 1ns/1ps

module hyperram_ddr_side
	import hyperbus_pkg::*, hyperram_cfg_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_i,
	input  hb_seq_t    seq_i,
	input  hb_pins_i_t hb_i,
	output logic       bus_clk_o,
	output hb_rdcnt_t  rd_cnt_o,
	output logic       rwds_2x_o,
	output hb_word_t   data_o
);

	logic      bus_clk_r;
	hb_rdcnt_t rd_cnt_r;
	logic      rwds_2x_r;
	logic      rwds_r;
	hb_word_t  data_r;
	logic      clk_active;
	logic      byte_valid;
	logic [1:0] lane;

	// last bus clock cycle of a read is not needed
	assign clk_active = (seq_i.phase inside {CA, LATENCY, WRITE})
		|| ((seq_i.phase == READ) && (rd_cnt_r >= 3'd2));

	// even byte counts land on rwds high, odd ones on the low half before
	assign byte_valid = (hb_i.rwds && !rd_cnt_r[0]) || (rwds_r && rd_cnt_r[0]);
	assign lane = rd_cnt_r[1:0] - 2'd1;

	always_ff @(negedge clk_i) begin
		if (seq_i.phase == READ) begin
			rwds_r <= hb_i.rwds;
		end
	end

	always_ff @(negedge clk_i) begin
		if (rst_i) begin
			bus_clk_r <= 1'b0;
			rd_cnt_r <= '0;
			rwds_2x_r <= 1'b1;
			data_r <= '0;
		end else begin
			bus_clk_r <= clk_active ? ~bus_clk_r : 1'b0;
			case (seq_i.phase)
				IDLE: begin
					// device default is 2x latency
					rwds_2x_r <= 1'b1;
				end
				PRE: begin
					data_r <= '0;
				end
				CA: begin
					if (seq_i.cnt == 6'd2) begin
						rwds_2x_r <= hb_i.rwds;
						rd_cnt_r <= seq_i.reg_access ? hb_rdcnt_t'(REG_BYTES)
							: hb_rdcnt_t'(MEM_BYTES);
					end
				end
				READ: begin
					if (byte_valid && (rd_cnt_r != '0)) begin
						rd_cnt_r <= rd_cnt_r - 1'b1;
						data_r[{lane, 3'b000} +: 8] <= hb_i.dq;
					end
				end
				default: begin
				end
			endcase
		end
	end

	assign bus_clk_o = bus_clk_r;
	assign rd_cnt_o = rd_cnt_r;
	assign rwds_2x_o = rwds_2x_r;
	assign data_o = data_r;

endmodule

//--- src/hyperram_sequencer.sv
`timescale 1ns/1ps

module hyperram_sequencer
	import hyperbus_pkg::*, hyperram_cfg_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       valid_i,
	input  hb_req_t    req_i,
	input  hb_timing_t timing_i,
	input  hb_rdcnt_t  rd_cnt_i,
	input  logic       rwds_2x_i,
	output hb_seq_t    seq_o,
	output hb_req_t    req_o,
	output logic       ready_o,
	output logic       read_timeout_o
);

	function automatic hb_timing_t clamp_timing(input hb_timing_t t);
		hb_timing_t c;
		c = t;
		if (t.tacc < MIN_TACC) begin
			c.tacc = MIN_TACC;
		end
		if (t.trmax < MIN_TIMEOUT) begin
			c.trmax = MIN_TIMEOUT;
		end
		return c;
	endfunction

	hb_phase_e  phase_r;
	hb_cnt_t    cnt_r;
	hb_timing_t timing_r;
	hb_req_t    req_r;
	logic       valid_r;
	logic       busy_r;
	logic       timeout_r;
	logic       start_accept;
	logic       read_op;
	logic       lat_2x;
	hb_cnt_t    lat_base;
	hb_cnt_t    latency_cycles;

	// new request only on the rising edge of valid_i while idle
	assign start_accept = valid_i && !valid_r && !busy_r;
	assign read_op = ~req_r.wren;

	// latency is tacc at 1x or 2x, counted in half bus clocks
	always_comb begin
		lat_2x = timing_r.fixed_latency ? timing_r.double_latency : rwds_2x_i;
		lat_base = lat_2x ? {timing_r.tacc, 2'b00} : {1'b0, timing_r.tacc, 1'b0};
		// reads take one more cycle for the delayed data
		latency_cycles = lat_base - (read_op ? 6'd2 : 6'd3);
	end

	always_ff @(posedge clk_i) begin
		if (start_accept) begin
			req_r <= req_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			phase_r <= IDLE;
			cnt_r <= {2'b00, DEFAULT_TIMING.tcsh};
			timing_r <= clamp_timing(DEFAULT_TIMING);
			valid_r <= 1'b0;
			busy_r <= 1'b0;
			timeout_r <= 1'b0;
		end else begin
			valid_r <= valid_i;
			case (phase_r)
				IDLE: begin
					// chip select high time still running from the last operation
					if (cnt_r != '0) begin
						cnt_r <= cnt_r - 1'b1;
					end
					if (start_accept) begin
						busy_r <= 1'b1;
						timeout_r <= 1'b0;
					end
					if ((cnt_r == '0) && (busy_r || start_accept)) begin
						phase_r <= PRE;
						cnt_r <= {2'b00, timing_i.tpre};
						timing_r <= clamp_timing(timing_i);
					end
				end
				PRE: begin
					if (cnt_r != '0) begin
						cnt_r <= cnt_r - 1'b1;
					end else begin
						phase_r <= CA;
						cnt_r <= hb_cnt_t'(CA_BYTES - 1);
					end
				end
				CA: begin
					if (cnt_r != '0) begin
						cnt_r <= cnt_r - 1'b1;
					end else if (!read_op && req_r.regspace) begin
						// register writes go straight to data
						phase_r <= WRITE;
						cnt_r <= hb_cnt_t'(REG_BYTES - 1);
					end else begin
						phase_r <= LATENCY;
						cnt_r <= latency_cycles;
					end
				end
				LATENCY: begin
					if (cnt_r != '0) begin
						cnt_r <= cnt_r - 1'b1;
					end else if (read_op) begin
						phase_r <= READ;
						cnt_r <= {timing_r.trmax, 1'b0} - 6'd2;
					end else begin
						phase_r <= WRITE;
						cnt_r <= hb_cnt_t'(MEM_BYTES - 1);
					end
				end
				WRITE: begin
					if (cnt_r != '0) begin
						cnt_r <= cnt_r - 1'b1;
					end else begin
						phase_r <= POST;
						cnt_r <= {2'b00, timing_r.tpost};
					end
				end
				READ: begin
					if ((cnt_r == '0) || (rd_cnt_i == '0)) begin
						phase_r <= POST;
						cnt_r <= {2'b00, timing_r.tpost};
						// device never marked all bytes valid
						timeout_r <= (cnt_r == '0) && (rd_cnt_i != '0);
					end else begin
						cnt_r <= cnt_r - 1'b1;
					end
				end
				POST: begin
					if (cnt_r != '0) begin
						cnt_r <= cnt_r - 1'b1;
					end else begin
						phase_r <= IDLE;
						cnt_r <= {2'b00, timing_r.tcsh};
						busy_r <= 1'b0;
					end
				end
				default: begin
					phase_r <= IDLE;
				end
			endcase
		end
	end

	assign seq_o = '{
		phase:      phase_r,
		cnt:        cnt_r,
		read_op:    read_op,
		reg_access: req_r.regspace
	};
	assign req_o = req_r;
	assign ready_o = ~busy_r;
	assign read_timeout_o = timeout_r;

	a_tacc_min: assert property (@(posedge clk_i) disable iff (rst_i)
		timing_r.tacc >= MIN_TACC);

	// host sees busy for the whole bus operation
	a_ready_idle: assert property (@(posedge clk_i) disable iff (rst_i)
		(phase_r != IDLE) |-> !ready_o);

	a_post_exit: assert property (@(posedge clk_i) disable iff (rst_i)
		(phase_r == POST) |=> (phase_r inside {POST, IDLE}));

endmodule

//--- src/hyperram_ctrl.sv
`timescale 1ns/1ps

module hyperram_ctrl
	import hyperbus_pkg::*, hyperram_cfg_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       valid_i,
	input  hb_req_t    req_i,
	input  hb_timing_t timing_i,
	output logic       ready_o,
	output hb_word_t   data_o,
	output logic       read_timeout_o,
	output hb_pins_o_t hb_o,
	input  hb_pins_i_t hb_i
);

	hb_seq_t   seq;
	hb_req_t   req_lat;
	hb_rdcnt_t rd_cnt;
	logic      rwds_2x;
	logic      bus_clk;
	hb_tx_t    tx;

	hyperram_sequencer seq0 (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.valid_i        (valid_i),
		.req_i          (req_i),
		.timing_i       (timing_i),
		.rd_cnt_i       (rd_cnt),
		.rwds_2x_i      (rwds_2x),
		.seq_o          (seq),
		.req_o          (req_lat),
		.ready_o        (ready_o),
		.read_timeout_o (read_timeout_o)
	);

	hyperram_tx tx0 (
		.rst_i (rst_i),
		.seq_i (seq),
		.req_i (req_lat),
		.tx_o  (tx)
	);

	hyperram_ddr_side ddr0 (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.seq_i     (seq),
		.hb_i      (hb_i),
		.bus_clk_o (bus_clk),
		.rd_cnt_o  (rd_cnt),
		.rwds_2x_o (rwds_2x),
		.data_o    (data_o)
	);

	// differential clock pair comes from the falling edge logic
	assign hb_o = '{
		rstn:     tx.rstn,
		csn:      tx.csn,
		clk:      bus_clk,
		clkn:     ~bus_clk,
		rwds:     tx.rwds,
		rwds_oen: tx.rwds_oen,
		dq:       tx.dq,
		dq_oen:   tx.dq_oen
	};

endmodule

//--- test/hyperram_dev_model.sv
`timescale 1ns/1ps

module hyperram_dev_model
	import hyperbus_pkg::*;
(
	input  hb_pins_o_t hb_i,
	output hb_pins_i_t hb_o,
	input  logic [3:0] tacc_i,
	input  logic       lat_2x_i,
	input  logic       silent_i
);

	logic [31:0] mem [0:63];
	logic [15:0] regs [0:1];
	logic [47:0] ca;
	logic [31:0] addr;
	logic [31:0] rd_word;
	logic        is_read;
	logic        is_reg;
	logic        rd_rwds = 1'b0;
	hb_byte_t    rd_dq = '0;
	logic        bus_clk;
	logic        csn;
	int          edge_idx = 0;
	int          data_start = 1000;
	int          nbytes = 4;
	int          i;

	assign bus_clk = hb_i.clk;
	assign csn = hb_i.csn;

	// latency request during command-address, read strobe afterwards
	assign hb_o = '{
		rwds: (!csn && (edge_idx < 6)) ? lat_2x_i : rd_rwds,
		dq:   rd_dq
	};

	initial begin
		for (int a = 0; a < 64; a++) begin
			mem[a] = {4{2'b01, 6'(a)}} ^ 32'hc3a5_5a3c;
		end
		regs[0] = 16'h8f1f;
		regs[1] = 16'h0002;
	end

	// every bus clock edge carries one byte
	always @(posedge bus_clk or negedge bus_clk or posedge csn) begin
		if (csn) begin
			edge_idx = 0;
			rd_rwds = 1'b0;
			rd_dq = '0;
		end else begin
			if (edge_idx < 6) begin
				ca[47 - 8 * edge_idx -: 8] = hb_i.dq;
			end
			if (edge_idx == 5) begin
				is_read = ca[47];
				is_reg = ca[46];
				addr = {ca[44:16], ca[2:0]};
				nbytes = is_reg ? 2 : 4;
				rd_word = is_reg ? {16'h0000, regs[addr[0]]} : mem[addr[5:0]];
				// register writes carry no latency
				if (is_reg && !is_read) begin
					data_start = 6;
				end else begin
					data_start = 4 + 2 * int'(tacc_i) * (lat_2x_i ? 2 : 1);
				end
			end else if ((edge_idx >= data_start) && (edge_idx < data_start + nbytes)) begin
				i = edge_idx - data_start;
				if (is_read) begin
					// silent device leaves rwds low, so no byte is ever valid
					if (!silent_i) begin
						rd_dq = rd_word[8 * (nbytes - 1 - i) +: 8];
						rd_rwds = (i % 2 == 0);
					end
				end else if (is_reg) begin
					regs[addr[0]][8 * (1 - i) +: 8] = hb_i.dq;
				end else if (!hb_i.rwds) begin
					mem[addr[5:0]][8 * (3 - i) +: 8] = hb_i.dq;
				end
			end
			edge_idx = edge_idx + 1;
		end
	end

endmodule

//--- test/tb_hyperram_ctrl.sv
`timescale 1ns/1ps

module tb_hyperram_ctrl
	import hyperbus_pkg::*, hyperram_cfg_pkg::*;
();

	localparam int unsigned SEED = 32'h026c_8a98;
	localparam int TIMEOUT_CYCLES = 400;

	logic        clk_i;
	logic        rst_i;
	logic        valid;
	hb_req_t     req;
	hb_timing_t  timing;
	logic        ready;
	hb_word_t    rdata;
	logic        rd_timeout;
	hb_pins_o_t  bus_out;
	hb_pins_i_t  bus_in;
	logic [3:0]  dev_tacc;
	logic        dev_2x;
	logic        dev_silent;
	hb_word_t    mem_img [0:63];
	logic [15:0] reg_img [0:1];
	int unsigned checks;
	int unsigned errors;
	int unsigned chk_mark;
	int unsigned err_mark;

	hyperram_ctrl dut0 (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.valid_i        (valid),
		.req_i          (req),
		.timing_i       (timing),
		.ready_o        (ready),
		.data_o         (rdata),
		.read_timeout_o (rd_timeout),
		.hb_o           (bus_out),
		.hb_i           (bus_in)
	);

	hyperram_dev_model dev0 (
		.hb_i     (bus_out),
		.hb_o     (bus_in),
		.tacc_i   (dev_tacc),
		.lat_2x_i (dev_2x),
		.silent_i (dev_silent)
	);

	initial begin
		clk_i = 1'b0;
		forever begin
			#10 clk_i = ~clk_i;
		end
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic abort_run(input string why);
		$display("run stopped at %0t: %s", $time, why);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic begin_test();
		chk_mark = checks;
		err_mark = errors;
	endtask

	task automatic end_test(input string name);
		$display("test %-12s %0d checks, %0d errors", name, checks - chk_mark,
			errors - err_mark);
	endtask

	function automatic hb_timing_t rand_timing();
		hb_timing_t t;
		t.tcsh = 4'($urandom);
		t.tpre = 4'($urandom);
		t.tpost = 4'($urandom);
		t.tacc = 4'($urandom_range(2, 15));
		t.trmax = 5'($urandom_range(4, 31));
		t.fixed_latency = 1'($urandom);
		t.double_latency = 1'($urandom);
		return t;
	endfunction

	function automatic hb_req_t make_req(input logic wr, input logic regsp, input logic [3:0] sel);
		hb_req_t r;
		r.wren = wr;
		r.regspace = regsp;
		r.addr = $urandom;
		r.sel = sel;
		r.data = $urandom;
		return r;
	endfunction

	// reference image follows the byte mask rules of the bus
	task automatic model_write(input hb_req_t r);
		if (r.regspace) begin
			reg_img[r.addr[0]] = r.data[15:0];
		end else begin
			for (int b = 0; b < 4; b++) begin
				if (r.sel[b]) begin
					mem_img[r.addr[5:0]][8 * b +: 8] = r.data[8 * b +: 8];
				end
			end
		end
	endtask

	function automatic hb_word_t expected_read(input hb_req_t r);
		if (r.regspace) begin
			return {16'h0000, reg_img[r.addr[0]]};
		end
		return mem_img[r.addr[5:0]];
	endfunction

	// one bus operation from the rising edge of valid until ready returns
	task automatic run_op(input hb_req_t r, input hb_timing_t t, input logic silent);
		int n;
		@(posedge clk_i);
		valid <= 1'b1;
		req <= r;
		timing <= t;
		dev_tacc <= (t.tacc < MIN_TACC) ? MIN_TACC : t.tacc;
		dev_2x <= t.fixed_latency ? t.double_latency : 1'($urandom);
		dev_silent <= silent;
		n = 0;
		@(negedge clk_i);
		while (ready && (n < TIMEOUT_CYCLES)) begin
			@(negedge clk_i);
			n++;
		end
		if (ready) begin
			abort_run("ready_o never dropped after a request");
		end else begin
			@(posedge clk_i);
			valid <= 1'b0;
			n = 0;
			@(negedge clk_i);
			while (!ready && (n < TIMEOUT_CYCLES)) begin
				@(negedge clk_i);
				n++;
			end
			if (!ready) begin
				abort_run("ready_o did not return after a bus operation");
			end
		end
	endtask

	task automatic write_op(input hb_req_t r, input hb_timing_t t);
		run_op(r, t, 1'b0);
		model_write(r);
	endtask

	task automatic read_check(input hb_req_t r, input hb_timing_t t, input string what);
		hb_req_t rd;
		rd = r;
		rd.wren = 1'b0;
		run_op(rd, t, 1'b0);
		check_value({what, " data"}, rdata, expected_read(rd));
		check_value({what, " timeout flag"}, 32'(rd_timeout), 32'd0);
	endtask

	// bus must be released whenever the host sees ready
	always @(negedge clk_i) begin
		if (!rst_i && ready) begin
			check_value("idle bus pins", 32'({bus_out.csn, bus_out.dq_oen, bus_out.rwds_oen}),
				32'd4);
		end
	end

	initial begin
		hb_req_t    r;
		hb_timing_t t;
		void'($urandom(SEED));
		checks = 0;
		errors = 0;
		rst_i = 1'b1;
		valid = 1'b0;
		req = '0;
		timing = DEFAULT_TIMING;
		dev_tacc = 4'd6;
		dev_2x = 1'b1;
		dev_silent = 1'b0;

		begin_test();
		repeat (7) @(posedge clk_i);
		@(negedge clk_i);
		check_value("rstn in reset", 32'(bus_out.rstn), 32'd0);
		check_value("csn in reset", 32'(bus_out.csn), 32'd1);
		check_value("bus clock in reset", 32'(bus_out.clk), 32'd0);
		check_value("inverted bus clock in reset", 32'(bus_out.clkn), 32'd1);
		check_value("dq enable in reset", 32'(bus_out.dq_oen), 32'd0);
		check_value("rwds enable in reset", 32'(bus_out.rwds_oen), 32'd0);
		check_value("ready in reset", 32'(ready), 32'd1);
		check_value("data in reset", rdata, 32'd0);
		check_value("timeout in reset", 32'(rd_timeout), 32'd0);
		@(posedge clk_i);
		rst_i <= 1'b0;
		@(negedge clk_i);
		check_value("rstn after reset", 32'(bus_out.rstn), 32'd1);
		end_test("reset");

		// full writes give the reference image a known start
		begin_test();
		for (int a = 0; a < 64; a++) begin
			r = make_req(1'b1, 1'b0, 4'hf);
			r.addr = {26'($urandom), 6'(a)};
			write_op(r, rand_timing());
		end
		for (int a = 0; a < 2; a++) begin
			r = make_req(1'b1, 1'b1, 4'hf);
			r.addr = {31'($urandom), 1'(a)};
			write_op(r, rand_timing());
		end
		end_test("preload");

		begin_test();
		for (int k = 0; k < 40; k++) begin
			r = make_req(1'b1, 1'b0, 4'($urandom));
			write_op(r, rand_timing());
			read_check(r, rand_timing(), "masked write");
		end
		end_test("mem_rw");

		begin_test();
		for (int k = 0; k < 10; k++) begin
			r = make_req(1'b1, 1'b1, 4'hf);
			write_op(r, rand_timing());
			read_check(r, rand_timing(), "register");
		end
		end_test("reg_rw");

		// fixed 1x, fixed 2x, then latency chosen by the device
		for (int mode = 0; mode < 3; mode++) begin
			begin_test();
			for (int k = 0; k < 20; k++) begin
				t = rand_timing();
				t.fixed_latency = (mode != 2);
				t.double_latency = (mode == 1);
				r = make_req(1'b0, 1'($urandom), 4'hf);
				read_check(r, t, "latency read");
			end
			end_test(mode == 0 ? "fixed_1x" : (mode == 1 ? "fixed_2x" : "variable"));
		end

		begin_test();
		for (int k = 0; k < 10; k++) begin
			r = make_req(1'b0, 1'($urandom), 4'hf);
			run_op(r, rand_timing(), 1'b1);
			check_value("silent read flag", 32'(rd_timeout), 32'd1);
			check_value("silent read data", rdata, 32'd0);
		end
		end_test("timeout");

		// values below the minimums are raised inside the DUT
		begin_test();
		for (int k = 0; k < 15; k++) begin
			t = rand_timing();
			t.tacc = 4'($urandom_range(0, 1));
			t.trmax = 5'($urandom_range(0, 3));
			r = make_req(1'b1, 1'($urandom), 4'($urandom));
			write_op(r, t);
			read_check(r, t, "clamped timing");
		end
		end_test("clamp");

		$display("total %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- hyperram_ctrl.f
src/hyperbus_pkg.sv
src/hyperram_cfg_pkg.sv
src/hyperram_tx.sv
src/hyperram_ddr_side.sv
src/hyperram_sequencer.sv
src/hyperram_ctrl.sv
test/hyperram_dev_model.sv
test/tb_hyperram_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_hyperram_ctrl
FILELIST  := hyperram_ctrl.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -qx "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
